// File: silencer_pkg.sv
package silencer_pkg;

  // array size, also the number of entries streamed per frame
  localparam int NUM_TRANS = 249;

  localparam int ADDR_W = 8;
  localparam int TABLE_DEPTH = 2 ** ADDR_W;

  // cycles from din_valid to dout_valid inside the silencer
  localparam int SIL_LATENCY = 3;

  typedef logic [ADDR_W-1:0] trans_idx_t;

  // intensity or phase code as seen by the host and the output stream
  typedef logic [7:0] drive8_t;

  // 8.8 fixed point, upper byte is the visible code
  typedef logic [15:0] drive16_t;

  // largest step per frame in the same 8.8 units as drive16_t
  typedef logic [15:0] rate_t;

  typedef logic [15:0] period_t;

  typedef enum logic {
    IDLE,
    STREAM
  } stream_state_t;

endpackage

// File: verilog/update_scheduler.sv
`timescale 1ns/1ps

module update_scheduler import silencer_pkg::*; (
  input  logic    CLK,
  input  logic    arst_n,
  input  logic    sched_en,
  input  period_t update_period,
  output logic    frame_start
);

  period_t cnt;

  // the counter sits at the reload value while disabled, so the first strobe
  // lands update_period cycles after sched_en is seen high
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      cnt         <= '0;
      frame_start <= 1'b0;
    end else if (!sched_en) begin
      cnt         <= update_period;
      frame_start <= 1'b0;
    end else if (cnt <= period_t'(1)) begin // also covers a zero period
      cnt         <= update_period;
      frame_start <= 1'b1;
    end else begin
      cnt         <= cnt - 1'b1;
      frame_start <= 1'b0;
    end
  end

endmodule

// File: verilog/gain_table.sv
`timescale 1ns/1ps

module gain_table import silencer_pkg::*; (
  input  logic       CLK,
  input  logic       arst_n,
  input  logic       wr_en,
  input  trans_idx_t wr_addr,
  input  drive8_t    wr_intensity,
  input  drive8_t    wr_phase,
  input  logic       frame_start,
  output logic       din_valid,
  output drive8_t    din_intensity,
  output drive8_t    din_phase
);

  localparam trans_idx_t LAST_ADDR = trans_idx_t'(NUM_TRANS - 1);

  drive8_t intensity_mem [TABLE_DEPTH];
  drive8_t phase_mem [TABLE_DEPTH];

  stream_state_t state;
  trans_idx_t    rd_addr;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      state     <= IDLE;
      rd_addr   <= '0;
      din_valid <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          din_valid <= 1'b0;
          if (frame_start) begin
            state   <= STREAM;
            rd_addr <= '0;
          end
        end
        STREAM: begin // a frame_start seen here is dropped
          din_valid <= 1'b1;
          rd_addr   <= rd_addr + 1'b1;
          if (rd_addr == LAST_ADDR) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // host writes land at any time, an entry not yet read still makes this frame
  always_ff @(posedge CLK) begin
    if (wr_en) begin
      intensity_mem[wr_addr] <= wr_intensity;
      phase_mem[wr_addr]     <= wr_phase;
    end
    if (state == STREAM) begin
      din_intensity <= intensity_mem[rd_addr];
      din_phase     <= phase_mem[rd_addr];
    end
  end

endmodule

// File: verilog/silencer.sv
`timescale 1ns/1ps

module silencer import silencer_pkg::*; (
  input  logic       CLK,
  input  logic       arst_n,
  input  logic       din_valid,
  input  drive8_t    din_intensity,
  input  drive8_t    din_phase,
  input  rate_t      rate_intensity,
  input  rate_t      rate_phase,
  output logic       dout_valid,
  output trans_idx_t dout_index,
  output drive8_t    dout_intensity,
  output drive8_t    dout_phase
);

  // limits a signed difference to plus or minus rate
  function automatic logic signed [17:0] clamp_step(logic signed [16:0] diff, rate_t rate);
    logic signed [17:0] d;
    logic signed [17:0] r;
    d = {diff[16], diff};
    r = {2'b00, rate};
    if (d > r) begin
      return r;
    end else if (d < -r) begin
      return -r;
    end
    return d;
  endfunction

  drive16_t cur_i_mem [TABLE_DEPTH];
  drive16_t cur_p_mem [TABLE_DEPTH];

  logic       in_prev;
  logic       primed;
  trans_idx_t idx_next;
  trans_idx_t rd_idx;
  drive16_t   rd_i;
  drive16_t   rd_p;

  logic               s1_valid;
  trans_idx_t         s1_idx;
  drive16_t           s1_cur_i;
  drive16_t           s1_cur_p;
  logic signed [16:0] s1_diff_i;
  logic signed [16:0] s1_diff_p;
  rate_t              s1_rate_i;
  rate_t              s1_rate_p;

  logic signed [17:0] diff_p_wide;
  logic signed [17:0] fold_p;

  logic               s2_valid;
  trans_idx_t         s2_idx;
  drive16_t           s2_cur_i;
  drive16_t           s2_cur_p;
  logic signed [16:0] s2_diff_i;
  logic signed [16:0] s2_diff_p;
  rate_t              s2_rate_i;
  rate_t              s2_rate_p;

  logic signed [17:0] step_i;
  logic signed [17:0] step_p;
  logic signed [17:0] sum_i;
  logic signed [17:0] sum_p;
  drive16_t           new_i;
  drive16_t           new_p;

  drive16_t out_i;
  drive16_t out_p;

  // a gap in din_valid means the next entry is transducer 0
  assign rd_idx = in_prev ? idx_next : '0;

  // memory content is undefined until a whole frame has gone through
  assign rd_i = primed ? cur_i_mem[rd_idx] : '0;
  assign rd_p = primed ? cur_p_mem[rd_idx] : '0;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      in_prev    <= 1'b0;
      idx_next   <= '0;
      primed     <= 1'b0;
      s1_valid   <= 1'b0;
      s2_valid   <= 1'b0;
      dout_valid <= 1'b0;
    end else begin
      in_prev <= din_valid;
      if (din_valid) begin
        idx_next <= rd_idx + 1'b1;
        if (rd_idx == trans_idx_t'(NUM_TRANS - 1)) begin
          primed <= 1'b1;
        end
      end
      s1_valid   <= din_valid;
      s2_valid   <= s1_valid;
      dout_valid <= s2_valid;
    end
  end

  // stage 1 reads the current pair and takes target minus current
  always_ff @(posedge CLK) begin
    s1_idx    <= rd_idx;
    s1_cur_i  <= rd_i;
    s1_cur_p  <= rd_p;
    s1_diff_i <= $signed({1'b0, din_intensity, 8'h00}) - $signed({1'b0, rd_i});
    s1_diff_p <= $signed({1'b0, din_phase, 8'h00}) - $signed({1'b0, rd_p});
    s1_rate_i <= rate_intensity;
    s1_rate_p <= rate_phase;
  end

  // phase takes the short way round, result lies in (-half turn, +half turn]
  always_comb begin
    diff_p_wide = {s1_diff_p[16], s1_diff_p};
    if (diff_p_wide > 18'sd32768) begin
      fold_p = diff_p_wide - 18'sd65536;
    end else if (diff_p_wide <= -18'sd32768) begin
      fold_p = diff_p_wide + 18'sd65536;
    end else begin
      fold_p = diff_p_wide;
    end
  end

  always_ff @(posedge CLK) begin
    s2_idx    <= s1_idx;
    s2_cur_i  <= s1_cur_i;
    s2_cur_p  <= s1_cur_p;
    s2_diff_i <= s1_diff_i;
    s2_diff_p <= fold_p[16:0];
    s2_rate_i <= s1_rate_i;
    s2_rate_p <= s1_rate_p;
  end

  always_comb begin
    step_i = clamp_step(s2_diff_i, s2_rate_i);
    step_p = clamp_step(s2_diff_p, s2_rate_p);
    sum_i  = $signed({2'b00, s2_cur_i}) + step_i; // never leaves 0..ffff, the step aims at target
    sum_p  = $signed({2'b00, s2_cur_p}) + step_p;
    new_i  = sum_i[15:0];
    new_p  = sum_p[15:0];                         // wraps modulo one turn
  end

  // stage 3 writes back in the same edge that loads the outputs
  always_ff @(posedge CLK) begin
    if (s2_valid) begin
      cur_i_mem[s2_idx] <= new_i;
      cur_p_mem[s2_idx] <= new_p;
    end
    dout_index <= s2_idx;
    out_i      <= new_i;
    out_p      <= new_p;
  end

  assign dout_intensity = out_i[15:8];
  assign dout_phase     = out_p[15:8];

endmodule

// File: verilog/silencer_top.sv
`timescale 1ns/1ps

module silencer_top import silencer_pkg::*; (
  input  logic       CLK,
  input  logic       arst_n,
  input  logic       wr_en,
  input  trans_idx_t wr_addr,
  input  drive8_t    wr_intensity,
  input  drive8_t    wr_phase,
  input  logic       sched_en,
  input  period_t    update_period,
  input  rate_t      rate_intensity,
  input  rate_t      rate_phase,
  output logic       dout_valid,
  output trans_idx_t dout_index,
  output drive8_t    dout_intensity,
  output drive8_t    dout_phase
);

  logic    frame_start;
  logic    din_valid;
  drive8_t din_intensity;
  drive8_t din_phase;

  update_scheduler u_sched (
    .CLK           (CLK),
    .arst_n        (arst_n),
    .sched_en      (sched_en),
    .update_period (update_period),
    .frame_start   (frame_start)
  );

  // one registered read per entry, first one a cycle after frame_start
  gain_table u_table (
    .CLK           (CLK),
    .arst_n        (arst_n),
    .wr_en         (wr_en),
    .wr_addr       (wr_addr),
    .wr_intensity  (wr_intensity),
    .wr_phase      (wr_phase),
    .frame_start   (frame_start),
    .din_valid     (din_valid),
    .din_intensity (din_intensity),
    .din_phase     (din_phase)
  );

  silencer u_silencer (
    .CLK            (CLK),
    .arst_n         (arst_n),
    .din_valid      (din_valid),
    .din_intensity  (din_intensity),
    .din_phase      (din_phase),
    .rate_intensity (rate_intensity),
    .rate_phase     (rate_phase),
    .dout_valid     (dout_valid),
    .dout_index     (dout_index),
    .dout_intensity (dout_intensity),
    .dout_phase     (dout_phase)
  );

endmodule

// File: tb/silencer_model.svh
`ifndef SILENCER_MODEL_SVH
`define SILENCER_MODEL_SVH

// targets in 8-bit codes as last written by the host
int model_tgt_i [NUM_TRANS];
int model_tgt_p [NUM_TRANS];

// current values in 8.8 fixed point that start at zero before the first frame
int model_cur_i [NUM_TRANS];
int model_cur_p [NUM_TRANS];

function automatic int limit_step(int diff, int rate);
  if (diff > rate) begin
    return rate;
  end
  if (diff < -rate) begin
    return -rate;
  end
  return diff;
endfunction

function automatic int next_intensity(int cur, int tgt, int rate);
  return cur + limit_step(tgt * 256 - cur, rate);
endfunction

// phase goes the short way and a difference of exactly half a turn goes up
function automatic int next_phase(int cur, int tgt, int rate);
  int diff;
  int sum;
  diff = tgt * 256 - cur;
  if (diff > 32768) begin
    diff = diff - 65536;
  end else if (diff <= -32768) begin
    diff = diff + 65536;
  end
  sum = cur + limit_step(diff, rate);
  return sum & 32'h0000_ffff;
endfunction

function automatic void clear_model();
  for (int k = 0; k < NUM_TRANS; k++) begin
    model_tgt_i[k] = 0;
    model_tgt_p[k] = 0;
    model_cur_i[k] = 0;
    model_cur_p[k] = 0;
  end
endfunction

`endif

// File: tb/tb_silencer_top.sv
`timescale 1ns/1ps

module tb_silencer_top import silencer_pkg::*; ();

  `include "silencer_model.svh"

  localparam int PERIOD = 300;
  localparam int MAX_FRAMES = 310;  // worst case over all tests
  localparam int WRITE_CYCLES = 3 * NUM_TRANS + 100;
  localparam int CYCLE_LIMIT = MAX_FRAMES * (PERIOD + NUM_TRANS + 8) + WRITE_CYCLES + 1000;

  logic       CLK;
  logic       arst_n;
  logic       wr_en;
  trans_idx_t wr_addr;
  drive8_t    wr_intensity;
  drive8_t    wr_phase;
  logic       sched_en;
  period_t    update_period;
  rate_t      rate_intensity;
  rate_t      rate_phase;
  logic       dout_valid;
  trans_idx_t dout_index;
  drive8_t    dout_intensity;
  drive8_t    dout_phase;

  int seed = 32'h572c_5277;
  int cyc = 0;
  int errors = 0;
  int checks = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int frames_done = 0;
  int run_len = 0;
  bit in_frame = 0;
  int frame_starts[$];
  int seen_cyc;
  int last_out_i [NUM_TRANS];
  int last_out_p [NUM_TRANS];
  int chk_k;
  int exp_i;
  int exp_p;
  int jump;

  silencer_top UUT (
    .CLK            (CLK),
    .arst_n         (arst_n),
    .wr_en          (wr_en),
    .wr_addr        (wr_addr),
    .wr_intensity   (wr_intensity),
    .wr_phase       (wr_phase),
    .sched_en       (sched_en),
    .update_period  (update_period),
    .rate_intensity (rate_intensity),
    .rate_phase     (rate_phase),
    .dout_valid     (dout_valid),
    .dout_index     (dout_index),
    .dout_intensity (dout_intensity),
    .dout_phase     (dout_phase)
  );

  always #5 CLK = ~CLK;

  // cycle count and watchdog
  always @(posedge CLK) begin
    cyc <= cyc + 1;
    if (cyc >= CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Checks failed");
      $finish;
    end
  end

  // true when the last output of every transducer equals its written target
  function automatic bit outputs_at_targets();
    for (int k = 0; k < NUM_TRANS; k++) begin
      if (last_out_i[k] != model_tgt_i[k] || last_out_p[k] != model_tgt_p[k]) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  // the output stream is compared with the model on the falling edge
  always @(negedge CLK) begin
    if (arst_n && dout_valid) begin
      if (!in_frame) begin
        frame_starts.push_back(cyc);
        run_len = 0;
      end
      in_frame = 1;
      chk_k = dout_index;
      checks++;
      assert (chk_k == run_len) else begin
        errors++;
        $display("mismatch at %0t: index got %0d expected %0d", $time, chk_k, run_len);
      end
      if (chk_k < NUM_TRANS) begin
        exp_i = next_intensity(model_cur_i[chk_k], model_tgt_i[chk_k], rate_intensity);
        exp_p = next_phase(model_cur_p[chk_k], model_tgt_p[chk_k], rate_phase);
        checks++;
        assert (dout_intensity == exp_i[15:8] && dout_phase == exp_p[15:8]) else begin
          errors++;
          $display("mismatch at %0t: idx %0d got %h/%h expected %h/%h", $time, chk_k,
                   dout_intensity, dout_phase, exp_i[15:8], exp_p[15:8]);
        end
        // a step never exceeds the rate plus one code for the fraction
        jump = int'(dout_intensity) - last_out_i[chk_k];
        if (jump < 0) begin
          jump = -jump;
        end
        checks++;
        assert (jump <= int'(rate_intensity >> 8) + 1) else begin
          errors++;
          $display("mismatch at %0t: idx %0d intensity jumped by %0d", $time, chk_k, jump);
        end
        last_out_i[chk_k] = dout_intensity;
        last_out_p[chk_k] = dout_phase;
        model_cur_i[chk_k] = exp_i;
        model_cur_p[chk_k] = exp_p;
      end
      run_len++;
    end else if (in_frame) begin
      in_frame = 0;
      checks++;
      assert (run_len == NUM_TRANS) else begin
        errors++;
        $display("mismatch at %0t: frame had %0d valid cycles instead of %0d", $time,
                 run_len, NUM_TRANS);
      end
      frames_done++;
    end
  end

  task automatic write_entry(int idx, int inten, int phase);
    @(negedge CLK);
    wr_en        = 1'b1;
    wr_addr      = trans_idx_t'(idx);
    wr_intensity = drive8_t'(inten);
    wr_phase     = drive8_t'(phase);
    model_tgt_i[idx] = inten;
    model_tgt_p[idx] = phase;
    @(negedge CLK);
    wr_en = 1'b0;
  endtask

  task automatic write_all_random();
    int rnd;
    for (int k = 0; k < NUM_TRANS; k++) begin
      @(negedge CLK);
      rnd          = $random(seed);
      wr_en        = 1'b1;
      wr_addr      = trans_idx_t'(k);
      wr_intensity = rnd[7:0];
      wr_phase     = rnd[15:8];
      model_tgt_i[k] = rnd[7:0];
      model_tgt_p[k] = rnd[15:8];
    end
    @(negedge CLK);
    wr_en = 1'b0;
  endtask

  // enables the scheduler for n frames and drops it after the last one
  task automatic run_frames(int n);
    int target;
    target = frames_done + n;
    @(negedge CLK);
    sched_en = 1'b1;
    @(negedge CLK);
    seen_cyc = cyc;
    while (frames_done < target) begin
      @(negedge CLK);
    end
    sched_en = 1'b0;
    repeat (2) @(negedge CLK);
  endtask

  task automatic close_test(string name, int err_before);
    tests_run++;
    if (errors > err_before) begin
      tests_failed++;
      $display("test %s: FAIL, %0d errors", name, errors - err_before);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  initial begin
    int e0;
    int first;
    int dmax;
    int d;
    int prev;
    bit saw_zero;
    int snap_i [NUM_TRANS];
    int snap_p [NUM_TRANS];

    CLK            = 1'b0;
    arst_n         = 1'b0;
    wr_en          = 1'b0;
    wr_addr        = '0;
    wr_intensity   = '0;
    wr_phase       = '0;
    sched_en       = 1'b0;
    update_period  = period_t'(PERIOD);
    rate_intensity = '0;
    rate_phase     = '0;
    clear_model();
    for (int k = 0; k < NUM_TRANS; k++) begin
      last_out_i[k] = 0;
      last_out_p[k] = 0;
    end
    repeat (4) @(posedge CLK);
    @(negedge CLK);
    arst_n = 1'b1;

    e0 = errors;
    repeat (60) begin
      @(negedge CLK);
      checks++;
      assert (!dout_valid) else begin
        errors++;
        $display("output valid while the scheduler is disabled");
      end
    end
    close_test("idle_after_reset", e0);

    write_all_random();

    // zero rates keep every output at zero while the frame shape is checked
    e0 = errors;
    first = frame_starts.size();
    run_frames(3);
    checks++;
    assert (frame_starts.size() == first + 3 && frame_starts[first] - seen_cyc == PERIOD + 4)
    else begin
      errors++;
      $display("first frame did not start %0d cycles after enable", PERIOD + 4);
    end
    for (int f = 1; f < 3; f++) begin
      checks++;
      assert (frame_starts[first + f] - frame_starts[first + f - 1] == PERIOD) else begin
        errors++;
        $display("frames %0d and %0d are not one period apart", f - 1, f);
      end
    end
    close_test("frame_shape", e0);

    e0 = errors;
    rate_intensity = 16'hffff;
    rate_phase     = 16'hffff;
    run_frames(1);
    checks++;
    assert (outputs_at_targets()) else begin
      errors++;
      $display("mismatch at %0t: full rate outputs are not the targets after one frame",
               $time);
    end
    close_test("full_rate", e0);

    e0 = errors;
    rate_intensity = 16'h0100;
    dmax = 0;
    write_all_random();
    for (int k = 0; k < NUM_TRANS; k++) begin
      d = model_tgt_i[k] - last_out_i[k];
      if (d < 0) begin
        d = -d;
      end
      if (d > dmax) begin
        dmax = d;
      end
    end
    if (dmax > 0) begin
      run_frames(dmax);
    end
    checks++;
    assert (outputs_at_targets()) else begin
      errors++;
      $display("mismatch at %0t: outputs are not the targets after %0d frames", $time, dmax);
    end
    close_test("intensity_rate", e0);

    e0 = errors;
    write_entry(5, model_tgt_i[5], 8'hf0);
    rate_phase = 16'hffff;
    run_frames(1);
    rate_phase = 16'h0400;
    write_entry(5, model_tgt_i[5], 8'h10);
    saw_zero = 0;
    repeat (8) begin
      prev = last_out_p[5];
      run_frames(1);
      checks++;
      assert (((last_out_p[5] - prev) & 32'hff) == 32'h04) else begin
        errors++;
        $display("mismatch at %0t: phase of transducer 5 went from %h to %h, not up by 4",
                 $time, prev, last_out_p[5]);
      end
      if (last_out_p[5] == 0) begin
        saw_zero = 1;
      end
    end
    checks++;
    assert (saw_zero && last_out_p[5] == 32'h10) else begin
      errors++;
      $display("phase did not wrap upward through zero");
    end
    write_entry(5, model_tgt_i[5], 8'hf0);
    saw_zero = 0;
    repeat (8) begin
      prev = last_out_p[5];
      run_frames(1);
      checks++;
      assert (((last_out_p[5] - prev) & 32'hff) == 32'hfc) else begin
        errors++;
        $display("mismatch at %0t: phase of transducer 5 went from %h to %h, not down by 4",
                 $time, prev, last_out_p[5]);
      end
      if (last_out_p[5] == 0) begin
        saw_zero = 1;
      end
    end
    checks++;
    assert (saw_zero && last_out_p[5] == 32'hf0) else begin
      errors++;
      $display("phase did not wrap downward back to f0");
    end
    close_test("phase_wrap", e0);

    e0 = errors;
    rate_intensity = 16'h0100;
    for (int k = 0; k < NUM_TRANS; k++) begin
      snap_i[k] = last_out_i[k];
      snap_p[k] = last_out_p[k];
    end
    write_entry(7, model_tgt_i[7] ^ 8'h20, model_tgt_p[7]);
    run_frames(32);
    for (int k = 0; k < NUM_TRANS; k++) begin
      checks++;
      if (k == 7) begin
        assert (last_out_i[7] == model_tgt_i[7] && last_out_p[7] == snap_p[7]) else begin
          errors++;
          $display("mismatch at %0t: transducer 7 shows %h/%h, not its new target", $time,
                   last_out_i[7], last_out_p[7]);
        end
      end else begin
        assert (last_out_i[k] == snap_i[k] && last_out_p[k] == snap_p[k]) else begin
          errors++;
          $display("mismatch at %0t: transducer %0d moved after a write to transducer 7",
                   $time, k);
        end
      end
    end
    close_test("host_write", e0);

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: silencer_top.f
+incdir+tb
silencer_pkg.sv
verilog/update_scheduler.sv
verilog/gain_table.sv
verilog/silencer.sv
verilog/silencer_top.sv
tb/tb_silencer_top.sv

// File: Makefile
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_silencer_top \
		-f silencer_top.f -o sim_tb
	./obj_dir/sim_tb | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
